// ==== hw/sd_cmd_pkg.sv ====
package sd_cmd_pkg;

    // bus word, also used for argument and card status
    typedef logic [31:0] sd_word_t;
    typedef logic [2:0]  reg_addr_t;
    typedef logic [5:0]  cmd_index_t;
    // card clock toggles every divisor+1 bus clocks
    typedef logic [7:0]  clk_div_t;
    typedef logic [3:0]  int_bits_t;

    // codes 2 and 3 behave as a short response
    typedef enum logic [1:0] {
        RSP_NONE  = 2'd0,
        RSP_SHORT = 2'd1
    } rsp_type_e;

    // register map, word addresses
    localparam reg_addr_t ADDR_ARGUMENT      = 3'd0;
    localparam reg_addr_t ADDR_COMMAND       = 3'd1;
    localparam reg_addr_t ADDR_RESPONSE      = 3'd2;
    localparam reg_addr_t ADDR_INT_STATUS    = 3'd3;
    localparam reg_addr_t ADDR_INT_ENABLE    = 3'd4;
    localparam reg_addr_t ADDR_CLOCK_DIVIDER = 3'd5;
    localparam reg_addr_t ADDR_CMD_TIMEOUT   = 3'd6;
    localparam reg_addr_t ADDR_PRESENT_STATE = 3'd7;

    // interrupt bit positions
    localparam int INT_COMPLETE  = 0;
    localparam int INT_TIMEOUT   = 1;
    localparam int INT_CRC_ERR   = 2;
    localparam int INT_INDEX_ERR = 3;

    localparam int CMD_FRAME_LEN = 48;
    localparam int CMD_TIMEOUT_W = 16;

    typedef struct packed {
        clk_div_t    divisor;
        logic [15:0] timeout;
        int_bits_t   int_enable;
    } sd_ctrl_t;

    typedef struct packed {
        cmd_index_t index;
        sd_word_t   argument;
        rsp_type_e  rsp_type;
    } cmd_req_t;

    typedef struct packed {
        cmd_index_t index;
        sd_word_t   status;
        logic       crc_ok;
        logic       timed_out;
    } cmd_rsp_t;

endpackage

// ==== hw/sd_wb_regs.sv ====
`timescale 1ns/1ps

module sd_wb_regs
    import sd_cmd_pkg::*;
#(
    parameter int CMD_TIMEOUT_W = sd_cmd_pkg::CMD_TIMEOUT_W
) (
    input  logic      wb_clk_i,
    input  logic      rst_n_i,
    input  logic      wb_cyc_i,
    input  logic      wb_stb_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_adr_i,
    input  sd_word_t  wb_dat_i,
    output sd_word_t  wb_dat_o,
    output logic      wb_ack_o,
    output sd_ctrl_t  ctrl_o,
    output sd_word_t  argument_o,
    output logic      cmd_write_o,
    output sd_word_t  cmd_word_o,
    output int_bits_t int_clear_o,
    input  logic      inhibit_i,
    input  sd_word_t  response_i,
    input  int_bits_t int_status_i
);

    sd_word_t                 argument_q;
    cmd_index_t               cmd_index_q;
    logic [1:0]               cmd_rsp_q;
    int_bits_t                int_enable_q;
    clk_div_t                 divisor_q;
    logic [CMD_TIMEOUT_W-1:0] timeout_q;
    logic                     ack_q;
    logic                     wr_stb;

    // one wait cycle, then a single ack cycle
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_cyc_i & wb_stb_i & ~ack_q;
        end
    end

    assign wb_ack_o = ack_q;
    // access is taken on the ack cycle
    assign wr_stb   = ack_q & wb_we_i;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            argument_q   <= '0;
            cmd_index_q  <= '0;
            cmd_rsp_q    <= '0;
            int_enable_q <= '0;
            divisor_q    <= '0;
            timeout_q    <= CMD_TIMEOUT_W'(64);
        end else if (wr_stb) begin
            case (wb_adr_i)
                ADDR_ARGUMENT: argument_q <= wb_dat_i;
                ADDR_COMMAND: begin
                    cmd_index_q <= wb_dat_i[5:0];
                    cmd_rsp_q   <= wb_dat_i[9:8];
                end
                ADDR_INT_ENABLE:    int_enable_q <= wb_dat_i[3:0];
                ADDR_CLOCK_DIVIDER: divisor_q    <= wb_dat_i[7:0];
                ADDR_CMD_TIMEOUT:   timeout_q    <= wb_dat_i[CMD_TIMEOUT_W-1:0];
                default: ;
            endcase
        end
    end

    // write pulses towards the command path
    assign cmd_write_o = wr_stb && (wb_adr_i == ADDR_COMMAND);
    assign cmd_word_o  = wb_dat_i;
    assign int_clear_o = (wr_stb && wb_adr_i == ADDR_INT_STATUS) ? wb_dat_i[3:0] : '0;

    // unused bits read as zero
    always_comb begin
        case (wb_adr_i)
            ADDR_ARGUMENT:      wb_dat_o = argument_q;
            ADDR_COMMAND:       wb_dat_o = {22'd0, cmd_rsp_q, 2'd0, cmd_index_q};
            ADDR_RESPONSE:      wb_dat_o = response_i;
            ADDR_INT_STATUS:    wb_dat_o = {28'd0, int_status_i};
            ADDR_INT_ENABLE:    wb_dat_o = {28'd0, int_enable_q};
            ADDR_CLOCK_DIVIDER: wb_dat_o = {24'd0, divisor_q};
            ADDR_CMD_TIMEOUT:   wb_dat_o = 32'(timeout_q);
            default:            wb_dat_o = {31'd0, inhibit_i};
        endcase
    end

    assign ctrl_o = '{divisor: divisor_q, timeout: 16'(timeout_q), int_enable: int_enable_q};
    assign argument_o = argument_q;

    // master must hold the request until ack
    ack_in_cycle: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wb_ack_o |-> wb_cyc_i && wb_stb_i)
        else $error("ack outside of cyc/stb");

endmodule

// ==== hw/sd_clock_divider.sv ====
`timescale 1ns/1ps

module sd_clock_divider
    import sd_cmd_pkg::*;
(
    input  logic     wb_clk_i,
    input  logic     rst_n_i,
    input  clk_div_t divisor_i,
    output logic     sd_clk_o,
    output logic     sd_rise_o,
    output logic     sd_fall_o
);

    clk_div_t count_q;
    logic     clk_q;
    logic     toggle;

    // compare with >= so a smaller divisor applies at once
    assign toggle = (count_q >= divisor_i);

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
            clk_q   <= 1'b0;
        end else if (toggle) begin
            count_q <= '0;
            clk_q   <= ~clk_q;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    // strobes sit in the cycle before the card clock edge
    assign sd_rise_o = toggle & ~clk_q;
    assign sd_fall_o = toggle & clk_q;
    assign sd_clk_o  = clk_q;

endmodule

// ==== hw/sd_cmd_decode.sv ====
`timescale 1ns/1ps

module sd_cmd_decode
    import sd_cmd_pkg::*;
(
    input  logic     wb_clk_i,
    input  logic     rst_n_i,
    input  logic     cmd_write_i,
    input  sd_word_t cmd_word_i,
    input  sd_word_t argument_i,
    input  logic     done_i,
    output logic     start_o,
    output cmd_req_t req_o,
    output logic     inhibit_o
);

    cmd_req_t req_q;
    logic     start_q;
    logic     inhibit_q;
    logic     accept;

    // writes during a running command are dropped
    assign accept = cmd_write_i & ~inhibit_q;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            start_q   <= 1'b0;
            inhibit_q <= 1'b0;
        end else begin
            start_q <= accept;
            if (accept) begin
                inhibit_q <= 1'b1;
            end else if (done_i) begin
                inhibit_q <= 1'b0;
            end
        end
    end

    // request stays stable until done
    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            req_q.index    <= cmd_word_i[5:0];
            req_q.argument <= argument_i;
            req_q.rsp_type <= rsp_type_e'(cmd_word_i[9:8]);
        end
    end

    assign start_o   = start_q;
    assign req_o     = req_q;
    assign inhibit_o = inhibit_q;

endmodule

// ==== hw/sd_cmd_serial_host.sv ====
`timescale 1ns/1ps

module sd_cmd_serial_host
    import sd_cmd_pkg::*;
#(
    parameter int CMD_TIMEOUT_W = sd_cmd_pkg::CMD_TIMEOUT_W
) (
    input  logic                     wb_clk_i,
    input  logic                     rst_n_i,
    input  logic                     sd_rise_i,
    input  logic                     sd_fall_i,
    input  logic                     start_i,
    input  cmd_req_t                 req_i,
    input  logic [CMD_TIMEOUT_W-1:0] timeout_i,
    input  logic                     sd_cmd_i,
    output logic                     sd_cmd_o,
    output logic                     sd_cmd_oe_o,
    output logic                     done_o,
    output cmd_rsp_t                 rsp_o
);

    typedef enum logic [2:0] {IDLE, SEND, WAIT_RSP, RECV, FINISH} state_e;

    state_e                   state_q;
    logic [CMD_FRAME_LEN-1:0] tx_shift_q;
    logic [CMD_FRAME_LEN-1:0] rx_shift_q;
    logic [5:0]               bit_cnt_q;
    logic [CMD_TIMEOUT_W-1:0] wait_cnt_q;
    logic                     timed_out_q;
    logic                     cmd_q;
    logic                     oe_q;
    logic [39:0]              tx_body;

    // CRC7, polynomial x^7 + x^3 + 1, msb first
    function automatic logic [6:0] crc7(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
        end
        return crc;
    endfunction

    // start bit, transmission bit, index, argument
    assign tx_body = {2'b01, req_i.index, req_i.argument};

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            bit_cnt_q   <= '0;
            wait_cnt_q  <= '0;
            timed_out_q <= 1'b0;
            cmd_q       <= 1'b1;
            oe_q        <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q     <= SEND;
                        bit_cnt_q   <= '0;
                        timed_out_q <= 1'b0;
                    end
                end
                SEND: begin
                    if (sd_fall_i && bit_cnt_q != 6'(CMD_FRAME_LEN)) begin
                        cmd_q     <= tx_shift_q[CMD_FRAME_LEN-1];
                        oe_q      <= 1'b1;
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end else if (sd_rise_i && bit_cnt_q == 6'(CMD_FRAME_LEN)) begin
                        // end bit was 1, so the line already rests high
                        oe_q       <= 1'b0;
                        wait_cnt_q <= '0;
                        state_q    <= (req_i.rsp_type == RSP_NONE) ? FINISH : WAIT_RSP;
                    end
                end
                WAIT_RSP: begin
                    if (sd_rise_i) begin
                        if (!sd_cmd_i) begin
                            bit_cnt_q <= 6'd1;
                            state_q   <= RECV;
                        end else if (wait_cnt_q == timeout_i) begin
                            timed_out_q <= 1'b1;
                            state_q     <= FINISH;
                        end else begin
                            wait_cnt_q <= wait_cnt_q + 1'b1;
                        end
                    end
                end
                RECV: begin
                    if (sd_rise_i) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 6'(CMD_FRAME_LEN - 1)) begin
                            state_q <= FINISH;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // shift paths; the start bit of the response is the first bit taken
    always_ff @(posedge wb_clk_i) begin
        if (state_q == IDLE && start_i) begin
            tx_shift_q <= {tx_body, crc7(tx_body), 1'b1};
        end else if (state_q == SEND && sd_fall_i) begin
            tx_shift_q <= {tx_shift_q[CMD_FRAME_LEN-2:0], 1'b1};
        end
        if (sd_rise_i && (state_q == RECV || (state_q == WAIT_RSP && !sd_cmd_i))) begin
            rx_shift_q <= {rx_shift_q[CMD_FRAME_LEN-2:0], sd_cmd_i};
        end
    end

    assign sd_cmd_o    = cmd_q;
    assign sd_cmd_oe_o = oe_q;
    assign done_o      = (state_q == FINISH);

    assign rsp_o.index     = rx_shift_q[45:40];
    assign rsp_o.status    = rx_shift_q[39:8];
    assign rsp_o.crc_ok    = (crc7(rx_shift_q[47:8]) == rx_shift_q[7:1]);
    assign rsp_o.timed_out = timed_out_q;

    // host drives the line only while the command goes out
    oe_only_in_send: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        sd_cmd_oe_o |-> state_q == SEND)
        else $error("command line driven outside SEND");

endmodule

// ==== hw/sd_cmd_result.sv ====
`timescale 1ns/1ps

module sd_cmd_result
    import sd_cmd_pkg::*;
(
    input  logic      wb_clk_i,
    input  logic      rst_n_i,
    input  logic      done_i,
    input  cmd_req_t  req_i,
    input  cmd_rsp_t  rsp_i,
    input  int_bits_t int_clear_i,
    input  int_bits_t int_enable_i,
    output sd_word_t  response_o,
    output int_bits_t int_status_o,
    output logic      irq_o
);

    int_bits_t status_q;
    int_bits_t set_bits;
    sd_word_t  response_q;
    logic      irq_q;
    logic      short_rsp;

    assign short_rsp = (req_i.rsp_type != RSP_NONE);

    always_comb begin
        set_bits = '0;
        if (done_i) begin
            set_bits[INT_COMPLETE] = 1'b1;
            if (short_rsp) begin
                if (rsp_i.timed_out) begin
                    set_bits[INT_TIMEOUT] = 1'b1;
                end else begin
                    set_bits[INT_CRC_ERR]   = ~rsp_i.crc_ok;
                    set_bits[INT_INDEX_ERR] = (rsp_i.index != req_i.index);
                end
            end
        end
    end

    // a new event wins over a clear in the same cycle
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            status_q   <= '0;
            response_q <= '0;
            irq_q      <= 1'b0;
        end else begin
            status_q <= (status_q & ~int_clear_i) | set_bits;
            irq_q    <= |(status_q & int_enable_i);
            if (done_i && short_rsp && !rsp_i.timed_out) begin
                response_q <= rsp_i.status;
            end
        end
    end

    assign response_o   = response_q;
    assign int_status_o = status_q;
    assign irq_o        = irq_q;

    // one done per command
    done_single: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        done_i |=> !done_i)
        else $error("done held for two cycles");

endmodule

// ==== hw/sd_cmd_top.sv ====
`timescale 1ns/1ps

module sd_cmd_top
    import sd_cmd_pkg::*;
#(
    parameter int CMD_TIMEOUT_W = sd_cmd_pkg::CMD_TIMEOUT_W
) (
    input  logic      wb_clk_i,
    input  logic      rst_n_i,
    input  logic      wb_cyc_i,
    input  logic      wb_stb_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_adr_i,
    input  sd_word_t  wb_dat_i,
    output sd_word_t  wb_dat_o,
    output logic      wb_ack_o,
    output logic      sd_clk_o,
    output logic      sd_cmd_o,
    output logic      sd_cmd_oe_o,
    input  logic      sd_cmd_i,
    output logic      irq_o
);

    sd_ctrl_t  ctrl;
    sd_word_t  argument;
    sd_word_t  cmd_word;
    sd_word_t  response;
    int_bits_t int_clear;
    int_bits_t int_status;
    cmd_req_t  req;
    cmd_rsp_t  rsp;
    logic      cmd_write;
    logic      inhibit;
    logic      sd_rise;
    logic      sd_fall;
    logic      start;
    logic      done;

    sd_wb_regs #(
        .CMD_TIMEOUT_W(CMD_TIMEOUT_W)
    ) sd_wb_regs_i (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .ctrl_o      (ctrl),
        .argument_o  (argument),
        .cmd_write_o (cmd_write),
        .cmd_word_o  (cmd_word),
        .int_clear_o (int_clear),
        .inhibit_i   (inhibit),
        .response_i  (response),
        .int_status_i(int_status)
    );

    sd_clock_divider sd_clock_divider_i (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .divisor_i(ctrl.divisor),
        .sd_clk_o (sd_clk_o),
        .sd_rise_o(sd_rise),
        .sd_fall_o(sd_fall)
    );

    sd_cmd_decode sd_cmd_decode_i (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .cmd_write_i(cmd_write),
        .cmd_word_i (cmd_word),
        .argument_i (argument),
        .done_i     (done),
        .start_o    (start),
        .req_o      (req),
        .inhibit_o  (inhibit)
    );

    sd_cmd_serial_host #(
        .CMD_TIMEOUT_W(CMD_TIMEOUT_W)
    ) sd_cmd_serial_host_i (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .sd_rise_i  (sd_rise),
        .sd_fall_i  (sd_fall),
        .start_i    (start),
        .req_i      (req),
        .timeout_i  (CMD_TIMEOUT_W'(ctrl.timeout)),
        .sd_cmd_i   (sd_cmd_i),
        .sd_cmd_o   (sd_cmd_o),
        .sd_cmd_oe_o(sd_cmd_oe_o),
        .done_o     (done),
        .rsp_o      (rsp)
    );

    sd_cmd_result sd_cmd_result_i (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .done_i      (done),
        .req_i       (req),
        .rsp_i       (rsp),
        .int_clear_i (int_clear),
        .int_enable_i(ctrl.int_enable),
        .response_o  (response),
        .int_status_o(int_status),
        .irq_o       (irq_o)
    );

endmodule

// ==== verif/sd_cmd_checker.sv ====
`timescale 1ns/1ps

module sd_cmd_checker
    import sd_cmd_pkg::*;
(
    input  logic      wb_clk_i,
    input  logic      rst_n_i,
    input  logic      wb_cyc_i,
    input  logic      wb_stb_i,
    input  logic      wb_we_i,
    input  logic      wb_ack_i,
    input  reg_addr_t wb_adr_i,
    input  sd_word_t  rd_data_i,
    input  logic      irq_i,
    input  logic      exp_valid_i,
    input  sd_word_t  exp_data_i,
    input  logic      irq_check_i,
    input  logic      irq_exp_i,
    output int        check_count_o,
    output int        error_count_o
);

    int checks = 0;
    int errors = 0;

    always @(posedge wb_clk_i) begin
        // read data is valid on the ack cycle
        if (rst_n_i && wb_cyc_i && wb_stb_i && wb_ack_i && !wb_we_i && exp_valid_i) begin
            checks++;
            if (rd_data_i !== exp_data_i) begin
                errors++;
                $display("Mismatch at %0t: register %0d read %h, expected %h",
                         $time, wb_adr_i, rd_data_i, exp_data_i);
            end
        end
        // interrupt line, sampled on request from the sequence
        if (rst_n_i && irq_check_i) begin
            checks++;
            if (irq_i !== irq_exp_i) begin
                errors++;
                if (irq_exp_i) begin
                    $display("irq_o stayed low at %0t although complete is pending and enabled",
                             $time);
                end else begin
                    $display("irq_o was still high at %0t after the status was cleared",
                             $time);
                end
            end
        end
    end

    assign check_count_o = checks;
    assign error_count_o = errors;

endmodule

// ==== verif/tb_sd_cmd.sv ====
`timescale 1ns/1ps

module tb_sd_cmd
    import sd_cmd_pkg::*;
();

    typedef enum logic [1:0] {KNOB_NONE, KNOB_BAD_CRC, KNOB_BAD_INDEX, KNOB_SILENT} knob_e;

    typedef struct packed {
        sd_word_t  response;
        int_bits_t status;
    } expect_t;

    // 6 commands, worst case divisor, frame plus wait plus bus traffic
    localparam int RUN_LIMIT = 6 * 2 * 256 * (96 + 64 + 20) + 2000;

    logic      wb_clk;
    logic      rst_n;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    reg_addr_t wb_adr;
    sd_word_t  wb_dat_w;
    sd_word_t  wb_dat_r;
    logic      wb_ack;
    logic      sd_clk;
    logic      sd_cmd_out;
    logic      sd_cmd_oe;
    logic      sd_cmd_in;
    logic      irq;
    logic      exp_valid;
    sd_word_t  exp_data;
    logic      irq_check;
    logic      irq_exp;
    int        check_count;
    int        error_count;
    knob_e     card_knob;
    logic      card_short;
    int        card_cmds = 0;
    int        card_errors = 0;
    int        seq_errors = 0;
    int        cycle_count = 0;
    int        tests_run = 0;
    int        tests_bad = 0;
    int        test_base = 0;
    sd_word_t  last_response = '0;

    sd_cmd_top sd_cmd_top_i (
        .wb_clk_i   (wb_clk),
        .rst_n_i    (rst_n),
        .wb_cyc_i   (wb_cyc),
        .wb_stb_i   (wb_stb),
        .wb_we_i    (wb_we),
        .wb_adr_i   (wb_adr),
        .wb_dat_i   (wb_dat_w),
        .wb_dat_o   (wb_dat_r),
        .wb_ack_o   (wb_ack),
        .sd_clk_o   (sd_clk),
        .sd_cmd_o   (sd_cmd_out),
        .sd_cmd_oe_o(sd_cmd_oe),
        .sd_cmd_i   (sd_cmd_in),
        .irq_o      (irq)
    );

    sd_cmd_checker sd_cmd_checker_i (
        .wb_clk_i     (wb_clk),
        .rst_n_i      (rst_n),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_ack_i     (wb_ack),
        .wb_adr_i     (wb_adr),
        .rd_data_i    (wb_dat_r),
        .irq_i        (irq),
        .exp_valid_i  (exp_valid),
        .exp_data_i   (exp_data),
        .irq_check_i  (irq_check),
        .irq_exp_i    (irq_exp),
        .check_count_o(check_count),
        .error_count_o(error_count)
    );

    initial begin
        wb_clk = 1'b0;
        forever #2 wb_clk = ~wb_clk;
    end

    always @(posedge wb_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == RUN_LIMIT) begin
            $display("run stopped after %0d cycles before the tests finished", RUN_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    // x^7 + x^3 + 1 over the 40 leading frame bits
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] crc;
        logic       inv;
        crc = 7'd0;
        for (int i = 39; i >= 0; i--) begin
            inv = bits[i] ^ crc[6];
            crc = crc << 1;
            if (inv) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    function automatic expect_t expected_result(input sd_word_t arg, input cmd_index_t index,
                                                input logic [1:0] rsp, input knob_e knob,
                                                input sd_word_t prev);
        expect_t e;
        e.status   = 4'b0001;
        e.response = prev;
        if (rsp != 2'd0) begin
            if (knob == KNOB_SILENT) begin
                e.status[INT_TIMEOUT] = 1'b1;
            end else begin
                e.response = ~arg;
                e.status[INT_CRC_ERR]   = (knob == KNOB_BAD_CRC);
                e.status[INT_INDEX_ERR] = (knob == KNOB_BAD_INDEX) && (index + 6'd1 != index);
            end
        end
        return e;
    endfunction

    function automatic int failures();
        return error_count + card_errors + seq_errors;
    endfunction

    // card: takes the command on rising edges, answers after falling edges
    initial begin : card_model
        logic [47:0] frame;
        logic [47:0] reply;
        cmd_index_t  index;
        sd_word_t    arg;
        logic        oe_bad;
        sd_cmd_in = 1'b1;
        forever begin
            @(posedge sd_clk);
            if (sd_cmd_oe && !sd_cmd_out) begin
                frame[47] = 1'b0;
                oe_bad    = 1'b0;
                for (int i = 46; i >= 0; i--) begin
                    @(posedge sd_clk);
                    frame[i] = sd_cmd_out;
                    // enable drops on the rise that takes the end bit
                    if (i > 0 && !sd_cmd_oe) begin
                        oe_bad = 1'b1;
                    end
                end
                card_cmds++;
                if (crc7_of(frame[47:8]) != frame[7:1] || !frame[46] || !frame[0]) begin
                    $display("card model got a badly framed command or a wrong CRC7 at %0t",
                             $time);
                    card_errors++;
                end
                @(negedge sd_clk);
                if (oe_bad || sd_cmd_oe) begin
                    $display("command line enable was wrong around the frame at %0t",
                             $time);
                    card_errors++;
                end
                index = frame[45:40];
                arg   = frame[39:8];
                if (card_short && card_knob != KNOB_SILENT) begin
                    if (card_knob == KNOB_BAD_INDEX) begin
                        index = index + 6'd1;
                    end
                    reply[47:8] = {2'b00, index, ~arg};
                    reply[7:1]  = crc7_of(reply[47:8]);
                    if (card_knob == KNOB_BAD_CRC) begin
                        reply[1] = ~reply[1];
                    end
                    reply[0] = 1'b1;
                    repeat (3) @(negedge sd_clk);
                    for (int i = 47; i >= 0; i--) begin
                        @(negedge wb_clk);
                        sd_cmd_in = reply[i];
                        @(negedge sd_clk);
                    end
                    @(negedge wb_clk);
                    sd_cmd_in = 1'b1;
                end
            end
        end
    end

    task automatic bus_cycle(input reg_addr_t adr, input logic we, input sd_word_t wdata,
                             input logic check, input sd_word_t expected,
                             output sd_word_t rdata);
        @(negedge wb_clk);
        wb_cyc    = 1'b1;
        wb_stb    = 1'b1;
        wb_we     = we;
        wb_adr    = adr;
        wb_dat_w  = wdata;
        exp_valid = check;
        exp_data  = expected;
        @(negedge wb_clk);
        while (!wb_ack) begin
            @(negedge wb_clk);
        end
        rdata = wb_dat_r;
        @(negedge wb_clk);
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        exp_valid = 1'b0;
    endtask

    task automatic wb_write(input reg_addr_t adr, input sd_word_t data);
        sd_word_t unused;
        bus_cycle(adr, 1'b1, data, 1'b0, '0, unused);
    endtask

    task automatic read_expect(input reg_addr_t adr, input sd_word_t expected);
        sd_word_t unused;
        bus_cycle(adr, 1'b0, '0, 1'b1, expected, unused);
    endtask

    task automatic read_value(input reg_addr_t adr, output sd_word_t data);
        bus_cycle(adr, 1'b0, '0, 1'b0, '0, data);
    endtask

    task automatic check_irq(input logic expected);
        @(negedge wb_clk);
        irq_check = 1'b1;
        irq_exp   = expected;
        @(negedge wb_clk);
        irq_check = 1'b0;
    endtask

    task automatic start_command(input cmd_index_t index, input sd_word_t arg,
                                 input logic [1:0] rsp, input knob_e knob);
        sd_word_t word;
        card_knob  = knob;
        card_short = (rsp != 2'd0);
        word       = $urandom();
        word[9:8]  = rsp;
        word[5:0]  = index;
        wb_write(ADDR_ARGUMENT, arg);
        wb_write(ADDR_COMMAND, word);
        read_expect(ADDR_COMMAND, {22'd0, rsp, 2'd0, index});
    endtask

    task automatic finish_command(input expect_t exp);
        sd_word_t st;
        st = '0;
        // latency depends on divisor and card, so poll for complete
        while (!st[INT_COMPLETE]) begin
            read_value(ADDR_INT_STATUS, st);
        end
        read_expect(ADDR_INT_STATUS, {28'd0, exp.status});
        read_expect(ADDR_RESPONSE, exp.response);
        read_expect(ADDR_PRESENT_STATE, 32'd0);
        check_irq(1'b1);
        wb_write(ADDR_INT_STATUS, 32'hf);
        read_expect(ADDR_INT_STATUS, 32'd0);
        check_irq(1'b0);
        last_response = exp.response;
    endtask

    task automatic run_command(input cmd_index_t index, input sd_word_t arg,
                               input logic [1:0] rsp, input knob_e knob);
        expect_t exp;
        exp = expected_result(arg, index, rsp, knob, last_response);
        start_command(index, arg, rsp, knob);
        finish_command(exp);
    endtask

    task automatic test_begin();
        test_base = failures();
    endtask

    task automatic test_end(input string name);
        int n;
        n = failures() - test_base;
        tests_run++;
        if (n == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, n);
        end
    endtask

    initial begin : stimulus
        cmd_index_t index;
        sd_word_t   arg;
        int         cmds_before;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        exp_valid  = 1'b0;
        exp_data   = '0;
        irq_check  = 1'b0;
        irq_exp    = 1'b0;
        card_knob  = KNOB_NONE;
        card_short = 1'b0;
        rst_n      = 1'b0;
        void'($urandom(32'ha905));
        repeat (4) @(posedge wb_clk);
        @(negedge wb_clk);
        rst_n = 1'b1;

        test_begin();
        read_expect(ADDR_CMD_TIMEOUT, 32'd64);
        read_expect(ADDR_CLOCK_DIVIDER, 32'd0);
        read_expect(ADDR_PRESENT_STATE, 32'd0);
        read_expect(ADDR_INT_STATUS, 32'd0);
        wb_write(ADDR_ARGUMENT, 32'hdead_beef);
        read_expect(ADDR_ARGUMENT, 32'hdead_beef);
        wb_write(ADDR_INT_ENABLE, 32'hffff_fff5);
        read_expect(ADDR_INT_ENABLE, 32'h5);
        wb_write(ADDR_CLOCK_DIVIDER, 32'h1234_56a7);
        read_expect(ADDR_CLOCK_DIVIDER, 32'ha7);
        wb_write(ADDR_CMD_TIMEOUT, 32'hbeef_0023);
        read_expect(ADDR_CMD_TIMEOUT, 32'h23);
        wb_write(ADDR_CMD_TIMEOUT, 32'd64);
        wb_write(ADDR_RESPONSE, 32'h5555_aaaa);
        read_expect(ADDR_RESPONSE, 32'd0);
        test_end("register access");

        test_begin();
        wb_write(ADDR_INT_ENABLE, 32'h1);
        wb_write(ADDR_CLOCK_DIVIDER, 32'd0);
        run_command(6'($urandom()), $urandom(), 2'($urandom_range(3, 1)), KNOB_NONE);
        wb_write(ADDR_CLOCK_DIVIDER, 32'd3);
        run_command(6'($urandom()), $urandom(), 2'($urandom_range(3, 1)), KNOB_NONE);
        test_end("short responses");

        test_begin();
        run_command(6'($urandom()), $urandom(), 2'd1, KNOB_BAD_CRC);
        test_end("response crc error");

        test_begin();
        run_command(6'($urandom()), $urandom(), 2'd1, KNOB_SILENT);
        test_end("response timeout");

        test_begin();
        run_command(6'($urandom()), $urandom(), 2'd1, KNOB_BAD_INDEX);
        test_end("response index error");

        test_begin();
        cmds_before = card_cmds;
        index       = 6'($urandom());
        arg         = $urandom();
        start_command(index, arg, 2'd0, KNOB_NONE);
        read_expect(ADDR_PRESENT_STATE, 32'd1);
        // must be dropped while the first one runs
        wb_write(ADDR_COMMAND, {22'd0, 2'd1, 2'd0, ~index});
        finish_command(expected_result(arg, index, 2'd0, KNOB_NONE, last_response));
        // room for a wrongly queued frame to show up
        repeat (CMD_FRAME_LEN + 8) @(posedge sd_clk);
        if (card_cmds - cmds_before != 1) begin
            $display("card model saw %0d commands where exactly one was expected",
                     card_cmds - cmds_before);
            seq_errors++;
        end
        test_end("no response and inhibit");

        $display("tests run %0d, with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, check_count, failures());
        if (tests_bad == 0 && failures() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/sd_cmd_pkg.sv
hw/sd_wb_regs.sv
hw/sd_clock_divider.sv
hw/sd_cmd_decode.sv
hw/sd_cmd_serial_host.sv
hw/sd_cmd_result.sv
hw/sd_cmd_top.sv
verif/sd_cmd_checker.sv
verif/tb_sd_cmd.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module tb_sd_cmd \
		-Mdir obj_dir -o tb_sd_cmd

run: compile
	./obj_dir/tb_sd_cmd | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
